//--- frame_disassembler.f
verilog/frame_disasm_pkg.sv
verilog/frame_sequencer.sv
verilog/pkt_slot.sv
verilog/link_status.sv
verilog/frame_disassembler.sv
tb/frame_disassembler_checker.sv
tb/frame_disassembler_tb.sv

//--- tb/frame_disassembler_checker.sv
`timescale 1ns/100ps

module frame_disassembler_checker
(
  input  logic                                                     clk,
  input  logic                                                     rst,
  input  frame_disasm_pkg::pkt_t [frame_disasm_pkg::num_chans-1:0] pkt,
  input  logic [frame_disasm_pkg::num_chans-1:0]                   pkt_vld,
  input  frame_disasm_pkg::ack_t                                   ack,
  input  logic                                                     ack_vld,
  input  logic                                                     frm_vld,
  input  logic                                                     frm_err,
  input  logic [frame_disasm_pkg::num_chans-1:0]                   cfc_rem
);

  // event kinds
  localparam logic [1:0] ev_ack = 2'd0;
  localparam logic [1:0] ev_err = 2'd1;
  localparam logic [1:0] ev_pkt = 2'd2;
  localparam logic [1:0] ev_frm = 2'd3;

  // one expected output event with fields used by kind
  typedef struct packed {
    logic [1:0]                             kind;
    logic [frame_disasm_pkg::slot_bits-1:0] slot;
    frame_disasm_pkg::pkt_t                 pkt;
    frame_disasm_pkg::ack_t                 ack;
    logic [frame_disasm_pkg::num_chans-1:0] mask;
  } exp_evt_t;

  // filled by the testbench and drained here in order
  exp_evt_t exp_q[$];
  string    cur_test     = "reset";
  int       mismatch_cnt = 0;
  int       missing_cnt  = 0;
  int       unexp_cnt    = 0;
  int       other_cnt    = 0;

  function automatic string kind_name(input logic [1:0] kind);
    case (kind)
      ev_ack:  return "ack_vld";
      ev_err:  return "frm_err";
      ev_pkt:  return "pkt_vld";
      default: return "frm_vld";
    endcase
  endfunction

  function automatic int pending();
    return exp_q.size();
  endfunction

  // --------------------
  // testbench side
  // --------------------
  task automatic start_test(input string name);
    cur_test = name;
  endtask

  task automatic add_event(input string kind, input logic [31:0] v0, input logic [31:0] v1,
                           input logic [31:0] v2, input logic [31:0] v3, input logic [31:0] v4);
    exp_evt_t e;
    e = '0;
    if (kind == "ack")
    begin
      e.kind       = ev_ack;
      e.ack.is_ack = v0[0];
      e.ack.clr    = v1[frame_disasm_pkg::clr_bits-1:0];
      e.ack.seq    = v2[frame_disasm_pkg::seq_bits-1:0];
    end
    else if (kind == "err")
      e.kind = ev_err;
    else if (kind == "pkt")
    begin
      e.kind        = ev_pkt;
      e.slot        = v0[frame_disasm_pkg::slot_bits-1:0];
      e.pkt.hdr     = v1[frame_disasm_pkg::hdr_bits-1:0];
      e.pkt.key     = v2;
      e.pkt.pld     = v3;
      e.pkt.has_pld = v4[0];
    end
    else
    begin
      e.kind = ev_frm;
      e.mask = v0[frame_disasm_pkg::num_chans-1:0];
    end
    exp_q.push_back(e);
  endtask

  task automatic note_failure(input string what);
    $display("%s in test %s", what, cur_test);
    other_cnt++;
  endtask

  // outputs straight after reset
  task automatic check_idle();
    if ((ack_vld !== 1'b0) || (frm_vld !== 1'b0) || (frm_err !== 1'b0) || (pkt_vld !== '0))
    begin
      $display("a valid or error output is not low after reset");
      other_cnt++;
    end
    if (cfc_rem !== '1)
    begin
      $display("Mismatch %s cfc_rem: expected %h, actual %h", cur_test, 8'hff, cfc_rem);
      mismatch_cnt++;
    end
  endtask

  // leftovers count as missing before the held mask is compared
  task automatic finish_test(input logic [frame_disasm_pkg::num_chans-1:0] rem);
    exp_evt_t e;
    while (exp_q.size() > 0)
    begin
      e = exp_q.pop_front();
      $display("expected %s pulse never came in test %s", kind_name(e.kind), cur_test);
      missing_cnt++;
    end
    if (cfc_rem !== rem)
    begin
      $display("Mismatch %s cfc_rem: expected %h, actual %h", cur_test, rem, cfc_rem);
      mismatch_cnt++;
    end
  endtask

  task automatic report_counts(output int total);
    total = mismatch_cnt + missing_cnt + unexp_cnt + other_cnt;
    $display("errors: %0d mismatch, %0d missing, %0d unexpected, %0d other",
             mismatch_cnt, missing_cnt, unexp_cnt, other_cnt);
  endtask

  // --------------------
  // output checks
  // --------------------
  task automatic check_ack();
    exp_evt_t e;
    if ((exp_q.size() == 0) || (exp_q[0].kind != ev_ack))
    begin
      $display("unexpected ack_vld pulse in test %s", cur_test);
      unexp_cnt++;
    end
    else
    begin
      e = exp_q.pop_front();
      if (ack !== e.ack)
      begin
        $display("Mismatch %s ack: expected %h, actual %h", cur_test, e.ack, ack);
        mismatch_cnt++;
      end
    end
  endtask

  task automatic check_err();
    exp_evt_t e;
    if ((exp_q.size() == 0) || (exp_q[0].kind != ev_err))
    begin
      $display("unexpected frm_err pulse in test %s", cur_test);
      unexp_cnt++;
    end
    else
      e = exp_q.pop_front();
  endtask

  // packets at the queue head come before the frame end
  task automatic check_frame();
    exp_evt_t                               e;
    frame_disasm_pkg::pkt_t                 got;
    logic [frame_disasm_pkg::num_chans-1:0] exp_vld;
    exp_vld = '0;
    while ((exp_q.size() > 0) && (exp_q[0].kind == ev_pkt))
    begin
      e                = exp_q.pop_front();
      got              = pkt[e.slot];
      exp_vld[e.slot]  = 1'b1;
      // payload only matters when one came with the packet
      if (!e.pkt.has_pld)
        e.pkt.pld = got.pld;
      if (got !== e.pkt)
      begin
        $display("Mismatch %s pkt[%0d]: expected %h, actual %h", cur_test, e.slot, e.pkt, got);
        mismatch_cnt++;
      end
    end
    if (pkt_vld !== exp_vld)
    begin
      $display("Mismatch %s pkt_vld: expected %b, actual %b", cur_test, exp_vld, pkt_vld);
      mismatch_cnt++;
    end
    if ((exp_q.size() > 0) && (exp_q[0].kind == ev_frm))
    begin
      e = exp_q.pop_front();
      if (frm_vld !== 1'b1)
      begin
        $display("frm_vld did not pulse with pkt_vld in test %s", cur_test);
        missing_cnt++;
      end
      if (cfc_rem !== e.mask)
      begin
        $display("Mismatch %s cfc_rem: expected %h, actual %h", cur_test, e.mask, cfc_rem);
        mismatch_cnt++;
      end
    end
    else
    begin
      $display("unexpected frame completion in test %s", cur_test);
      unexp_cnt++;
    end
  endtask

  // registered outputs are stable at the rising edge
  always @(posedge clk)
  begin
    if (!rst)
    begin
      if (ack_vld)
        check_ack();
      if (frm_err)
        check_err();
      if (frm_vld || (pkt_vld != '0))
        check_frame();
    end
  end

endmodule

//--- tb/frame_disassembler_tb.sv
`timescale 1ns/100ps

module frame_disassembler_tb;

  // cycles allowed for expected outputs to show up
  localparam int drain_limit   = 64;
  // extra cycles to catch stray pulses
  localparam int settle_cycles = 4;

  logic                                                     clk;
  logic                                                     rst;
  frame_disasm_pkg::link_word_t                             link_in;
  frame_disasm_pkg::pkt_t [frame_disasm_pkg::num_chans-1:0] pkt;
  logic [frame_disasm_pkg::num_chans-1:0]                   pkt_vld;
  frame_disasm_pkg::ack_t                                   ack;
  logic                                                     ack_vld;
  logic                                                     frm_vld;
  logic                                                     frm_err;
  logic [frame_disasm_pkg::num_chans-1:0]                   cfc_rem;

  // words of the test being loaded
  logic [frame_disasm_pkg::word_bits-1:0] word_q[$];
  logic [frame_disasm_pkg::kch_bits-1:0]  kchr_q[$];
  int                                     idle_q[$];
  logic [frame_disasm_pkg::num_chans-1:0] exp_rem;
  int                                     seed;
  int                                     fd;
  int                                     total;

  frame_disassembler frame_disassembler_i
  (
    .clk     (clk),
    .rst     (rst),
    .link_in (link_in),
    .pkt     (pkt),
    .pkt_vld (pkt_vld),
    .ack     (ack),
    .ack_vld (ack_vld),
    .frm_vld (frm_vld),
    .frm_err (frm_err),
    .cfc_rem (cfc_rem)
  );

  frame_disassembler_checker chk_i
  (
    .clk     (clk),
    .rst     (rst),
    .pkt     (pkt),
    .pkt_vld (pkt_vld),
    .ack     (ack),
    .ack_vld (ack_vld),
    .frm_vld (frm_vld),
    .frm_err (frm_err),
    .cfc_rem (cfc_rem)
  );

  // 4 ns period
  always #2 clk = ~clk;

  // --------------------
  // stimulus
  // --------------------
  // idle cycles carry random junk with vld low
  task automatic send_word(input logic [31:0] data, input logic [3:0] kchr, input int idle);
    int          gap;
    logic [31:0] junk;
    gap = idle + ($unsigned($random(seed)) % 3);
    repeat (gap)
    begin
      @(negedge clk);
      link_in.vld  = 1'b0;
      link_in.data = $random(seed);
      junk         = $random(seed);
      link_in.kchr = junk[frame_disasm_pkg::kch_bits-1:0];
    end
    @(negedge clk);
    link_in.data = data;
    link_in.kchr = kchr;
    link_in.vld  = 1'b1;
  endtask

  task automatic run_test();
    int waited;
    while (word_q.size() > 0)
      send_word(word_q.pop_front(), kchr_q.pop_front(), idle_q.pop_front());
    @(negedge clk);
    link_in.vld = 1'b0;
    // wait for the checker to consume every expected event
    waited = 0;
    while ((chk_i.pending() > 0) && (waited < drain_limit))
    begin
      @(negedge clk);
      waited++;
    end
    if (chk_i.pending() > 0)
      chk_i.note_failure("timed out waiting for expected outputs");
    repeat (settle_cycles) @(negedge clk);
    chk_i.finish_test(exp_rem);
  endtask

  // --------------------
  // test file parsing
  // --------------------
  task automatic load_tests();
    string       tok;
    string       name;
    string       rest;
    logic [31:0] v0;
    logic [31:0] v1;
    logic [31:0] v2;
    logic [31:0] v3;
    logic [31:0] v4;
    int          idle;
    int          r;
    logic        done;
    done = 1'b0;
    while (!done)
    begin
      if ($fscanf(fd, "%s", tok) != 1)
        done = 1'b1;
      else if (tok == "#")
        r = $fgets(rest, fd);
      else if (tok == "test")
      begin
        r = $fscanf(fd, "%s", name);
        chk_i.start_test(name);
      end
      else if (tok == "w")
      begin
        r = $fscanf(fd, "%h %h %d", v0, v1, idle);
        word_q.push_back(v0);
        kchr_q.push_back(v1[frame_disasm_pkg::kch_bits-1:0]);
        idle_q.push_back(idle);
      end
      else if (tok == "ack")
      begin
        r = $fscanf(fd, "%h %h %h", v0, v1, v2);
        chk_i.add_event(tok, v0, v1, v2, '0, '0);
      end
      else if (tok == "err")
        chk_i.add_event(tok, '0, '0, '0, '0, '0);
      else if (tok == "pkt")
      begin
        r = $fscanf(fd, "%h %h %h %h %h", v0, v1, v2, v3, v4);
        chk_i.add_event(tok, v0, v1, v2, v3, v4);
      end
      else if (tok == "frm")
      begin
        r = $fscanf(fd, "%h", v0);
        chk_i.add_event(tok, v0, '0, '0, '0, '0);
      end
      else if (tok == "rem")
        r = $fscanf(fd, "%h", exp_rem);
      else if (tok == "end")
        run_test();
      else
      begin
        chk_i.note_failure({"unknown keyword ", tok, " in test file"});
        done = 1'b1;
      end
    end
  endtask

  // --------------------
  // main sequence
  // --------------------
  initial
  begin
    seed    = 88319;
    clk     = 1'b0;
    rst     = 1'b1;
    link_in = '0;
    exp_rem = '1;
    repeat (3) @(negedge clk);
    rst = 1'b0;
    chk_i.check_idle();
    fd = $fopen("tb/frame_disassembler_tests.txt", "r");
    if (fd == 0)
      chk_i.note_failure("cannot open tb/frame_disassembler_tests.txt");
    else
    begin
      load_tests();
      $fclose(fd);
    end
    chk_i.report_counts(total);
    if (total == 0)
      $display("Test passed");
    else
      $display("Test failed");
    $finish;
  end

endmodule

//--- tb/frame_disassembler_tests.txt
# w <data hex> <kchr hex> <idle cycles>, ack <is_ack> <clr> <seq>, err
# pkt <slot> <hdr> <key> <pld> <has_pld>, frm <cfc_rem>, rem <cfc_rem at end>, end
test ack_nak
w dca50000 8 0
w fc130000 8 2
ack 1 1 25
ack 0 0 13
rem ff
end
test cfc_frame
w 3c0000a6 8 1
rem a6
end
test data_mixed
w 5c552921 8 0
w 44332211 0 0
w 88776655 0 1
w 10000000 0 0
w 20000000 0 0
w 30000003 0 2
w 50000005 0 0
w 60000006 0 0
w 000000c3 0 0
pkt 0 11 10000000 20000000 1
pkt 3 44 30000003 0 0
pkt 5 66 50000005 60000006 1
frm c3
rem c3
end
test data_bad_mid
w 5c000301 8 0
w aabbccdd 0 0
w 00000000 0 0
w 12345678 1 0
err
rem c3
end
test data_after_err
w 5c008080 8 0
w 00000000 0 0
w ab000000 0 0
w 70000007 0 1
w 80000008 0 0
w 0000000f 0 0
pkt 7 ab 70000007 80000008 1
frm 0f
rem 0f
end
test unknown_first
w 7c000000 8 0
w dc000000 c 1
err
err
rem 0f
end

//--- verilog/frame_disasm_pkg.sv
package frame_disasm_pkg;

  // --------------------
  // sizes
  // --------------------
  localparam int word_bits = 32;
  localparam int kch_bits  = 4;
  localparam int num_chans = 8;
  localparam int slot_bits = $clog2(num_chans);
  localparam int clr_bits  = 1;
  localparam int seq_bits  = 7;
  localparam int hdr_bits  = 8;
  localparam int code_bits = 8;

  // headers packed four to a word and two header words per frame
  localparam int hdr_per_word = word_bits / hdr_bits;
  localparam int hdr_words    = num_chans / hdr_per_word;

  // --------------------
  // k-character codes
  // --------------------
  // first word has a k-char in the top byte only
  localparam logic [kch_bits-1:0]  kch_first = 4'b1000;
  localparam logic [code_bits-1:0] kch_data  = 8'h5c;
  localparam logic [code_bits-1:0] kch_ack   = 8'hdc;
  localparam logic [code_bits-1:0] kch_nak   = 8'hfc;
  localparam logic [code_bits-1:0] kch_cfc   = 8'h3c;

  // --------------------
  // first-word layout
  // --------------------
  localparam int frm_code_lsb = 24;
  localparam int frm_clr_bit  = 23;
  localparam int frm_seq_lsb  = 16;
  // presence mask of data frames only
  localparam int frm_pre_lsb  = 8;
  // payload mask (data) or flow-control mask (cfc and last word)
  localparam int frm_msk_lsb  = 0;

  // receive frame states
  typedef enum logic [2:0] {
    st_start,
    st_hdr0,
    st_hdr1,
    st_key,
    st_pld,
    st_last
  } frm_state_t;

  // --------------------
  // bundles
  // --------------------
  typedef struct packed {
    logic [word_bits-1:0] data;
    logic [kch_bits-1:0]  kchr;
    logic                 vld;
  } link_word_t;

  typedef struct packed {
    logic [hdr_bits-1:0]  hdr;
    logic [word_bits-1:0] key;
    logic [word_bits-1:0] pld;
    logic                 has_pld;
  } pkt_t;

  // one hdr strobe bit per header word and key/pld qualified by sel
  typedef struct packed {
    logic [word_bits-1:0] word;
    logic [num_chans-1:0] sel;
    logic [hdr_words-1:0] hdr;
    logic                 key;
    logic                 pld;
  } slot_wr_t;

  typedef struct packed {
    logic                 ack;
    logic                 nak;
    logic                 cfc;
    logic                 dat_end;
    logic                 frm_err;
    logic [clr_bits-1:0]  clr;
    logic [seq_bits-1:0]  seq;
    logic [num_chans-1:0] mask;
  } word_evt_t;

  typedef struct packed {
    logic                is_ack;
    logic [clr_bits-1:0] clr;
    logic [seq_bits-1:0] seq;
  } ack_t;

endpackage

//--- verilog/frame_disassembler.sv
`timescale 1ns/100ps

module frame_disassembler
(
  input  logic                                   clk,
  input  logic                                   rst,

  // link words from the transceiver
  input  frame_disasm_pkg::link_word_t           link_in,

  // one packet per channel slot
  output frame_disasm_pkg::pkt_t [frame_disasm_pkg::num_chans-1:0] pkt,
  output logic [frame_disasm_pkg::num_chans-1:0] pkt_vld,

  // acknowledge to the transmit side
  output frame_disasm_pkg::ack_t                 ack,
  output logic                                   ack_vld,

  // frame status
  output logic                                   frm_vld,
  output logic                                   frm_err,

  // remote channel mask
  output logic [frame_disasm_pkg::num_chans-1:0] cfc_rem
);

  frame_disasm_pkg::slot_wr_t             slot_wr;
  frame_disasm_pkg::word_evt_t            evt;
  logic [frame_disasm_pkg::num_chans-1:0] pkt_commit;

  // --------------------
  // frame control
  // --------------------
  frame_sequencer frame_sequencer_i
  (
    .clk        (clk),
    .rst        (rst),
    .link_in    (link_in),
    .slot_wr    (slot_wr),
    .pkt_commit (pkt_commit),
    .evt        (evt)
  );

  // --------------------
  // packet slots
  // --------------------
  // every slot sees the same write bus and picks its own fields
  for (genvar i = 0; i < frame_disasm_pkg::num_chans; i++)
  begin : slot_gen
    pkt_slot
    #(
      .slot_idx (i)
    )
    pkt_slot_i
    (
      .clk     (clk),
      .rst     (rst),
      .slot_wr (slot_wr),
      .commit  (pkt_commit[i]),
      .pkt     (pkt[i]),
      .pkt_vld (pkt_vld[i])
    );
  end

  // --------------------
  // status outputs
  // --------------------
  link_status link_status_i
  (
    .clk     (clk),
    .rst     (rst),
    .evt     (evt),
    .ack     (ack),
    .ack_vld (ack_vld),
    .frm_vld (frm_vld),
    .frm_err (frm_err),
    .cfc_rem (cfc_rem)
  );

endmodule

//--- verilog/frame_sequencer.sv
`timescale 1ns/100ps

module frame_sequencer
(
  input  logic                                   clk,
  input  logic                                   rst,
  input  frame_disasm_pkg::link_word_t           link_in,
  output frame_disasm_pkg::slot_wr_t             slot_wr,
  output logic [frame_disasm_pkg::num_chans-1:0] pkt_commit,
  output frame_disasm_pkg::word_evt_t            evt
);

  frame_disasm_pkg::frm_state_t           state;
  frame_disasm_pkg::frm_state_t           nxt_state;
  frame_disasm_pkg::frm_state_t           adv_state;
  logic [frame_disasm_pkg::slot_bits-1:0] cur_slot;
  logic [frame_disasm_pkg::slot_bits-1:0] nxt_cur;
  logic [frame_disasm_pkg::slot_bits-1:0] nxt_slot;
  logic                                   nxt_found;
  logic [frame_disasm_pkg::num_chans-1:0] pre_msk;
  logic [frame_disasm_pkg::num_chans-1:0] pld_msk;
  logic [frame_disasm_pkg::code_bits-1:0] code;
  logic                                   in_start;
  logic                                   is_first;
  logic                                   ack_w;
  logic                                   nak_w;
  logic                                   cfc_w;
  logic                                   dat_w;
  logic                                   frm_err;
  logic                                   good;

  // --------------------
  // word decode
  // --------------------
  assign in_start = (state == frame_disasm_pkg::st_start);
  assign code     = link_in.data[frame_disasm_pkg::frm_code_lsb +: frame_disasm_pkg::code_bits];

  // a first word has a k-char in the top byte only
  assign is_first = link_in.vld && in_start && (link_in.kchr == frame_disasm_pkg::kch_first);

  assign ack_w = is_first && (code == frame_disasm_pkg::kch_ack);
  assign nak_w = is_first && (code == frame_disasm_pkg::kch_nak);
  assign cfc_w = is_first && (code == frame_disasm_pkg::kch_cfc);
  assign dat_w = is_first && (code == frame_disasm_pkg::kch_data);

  // unknown first word or any k-char inside a data frame
  always_comb
  begin
    if (!link_in.vld)
      frm_err = 1'b0;
    else if (in_start)
      frm_err = !(ack_w || nak_w || cfc_w || dat_w);
    else
      frm_err = (link_in.kchr != '0);
  end

  assign good = link_in.vld && !frm_err;

  // --------------------
  // next present slot
  // --------------------
  // lowest present slot above the current one or any slot after the headers
  always_comb
  begin
    nxt_found = 1'b0;
    nxt_slot  = '0;
    for (int i = frame_disasm_pkg::num_chans - 1; i >= 0; i--)
    begin
      if (pre_msk[i] && ((state == frame_disasm_pkg::st_hdr1) || (i > int'(cur_slot))))
      begin
        nxt_found = 1'b1;
        nxt_slot  = frame_disasm_pkg::slot_bits'(i);
      end
    end
  end

  // no more packets means the last word is next
  assign adv_state = nxt_found ? frame_disasm_pkg::st_key : frame_disasm_pkg::st_last;

  // --------------------
  // frame fsm
  // --------------------
  always_comb
  begin
    nxt_state = state;
    nxt_cur   = cur_slot;
    if (link_in.vld)
    begin
      if (frm_err)
        nxt_state = frame_disasm_pkg::st_start;
      else
        case (state)
          frame_disasm_pkg::st_start:
          begin
            // ack, nak and cfc are single-word frames
            if (dat_w)
              nxt_state = frame_disasm_pkg::st_hdr0;
          end
          frame_disasm_pkg::st_hdr0:
            nxt_state = frame_disasm_pkg::st_hdr1;
          frame_disasm_pkg::st_key:
          begin
            if (pld_msk[cur_slot])
              nxt_state = frame_disasm_pkg::st_pld;
            else
            begin
              nxt_state = adv_state;
              nxt_cur   = nxt_slot;
            end
          end
          frame_disasm_pkg::st_hdr1,
          frame_disasm_pkg::st_pld:
          begin
            nxt_state = adv_state;
            nxt_cur   = nxt_slot;
          end
          default:
            nxt_state = frame_disasm_pkg::st_start;
        endcase
    end
  end

  always_ff @(posedge clk or posedge rst)
  begin
    if (rst)
    begin
      state    <= frame_disasm_pkg::st_start;
      cur_slot <= '0;
    end
    else
    begin
      state    <= nxt_state;
      cur_slot <= nxt_cur;
    end
  end

  // masks held for the whole data frame
  always_ff @(posedge clk or posedge rst)
  begin
    if (rst)
    begin
      pre_msk <= '0;
      pld_msk <= '0;
    end
    else if (dat_w)
    begin
      pre_msk <= link_in.data[frame_disasm_pkg::frm_pre_lsb +: frame_disasm_pkg::num_chans];
      pld_msk <= link_in.data[frame_disasm_pkg::frm_msk_lsb +: frame_disasm_pkg::num_chans];
    end
  end

  // --------------------
  // slot writes
  // --------------------
  always_comb
  begin
    slot_wr.word   = link_in.data;
    slot_wr.sel    = frame_disasm_pkg::num_chans'(1) << cur_slot;
    slot_wr.hdr    = '0;
    slot_wr.hdr[0] = good && (state == frame_disasm_pkg::st_hdr0);
    slot_wr.hdr[1] = good && (state == frame_disasm_pkg::st_hdr1);
    slot_wr.key    = good && (state == frame_disasm_pkg::st_key);
    slot_wr.pld    = good && (state == frame_disasm_pkg::st_pld);
  end

  // --------------------
  // events
  // --------------------
  always_comb
  begin
    evt.ack     = ack_w;
    evt.nak     = nak_w;
    evt.cfc     = cfc_w;
    evt.dat_end = good && (state == frame_disasm_pkg::st_last);
    evt.frm_err = frm_err;
    evt.clr     = link_in.data[frame_disasm_pkg::frm_clr_bit];
    evt.seq     = link_in.data[frame_disasm_pkg::frm_seq_lsb +: frame_disasm_pkg::seq_bits];
    // cfc word and last data word share this field
    evt.mask    = link_in.data[frame_disasm_pkg::frm_msk_lsb +: frame_disasm_pkg::num_chans];
  end

  // release every present slot at once
  assign pkt_commit = evt.dat_end ? pre_msk : '0;

endmodule

//--- verilog/link_status.sv
`timescale 1ns/100ps

module link_status
(
  input  logic                                   clk,
  input  logic                                   rst,
  input  frame_disasm_pkg::word_evt_t            evt,
  output frame_disasm_pkg::ack_t                 ack,
  output logic                                   ack_vld,
  output logic                                   frm_vld,
  output logic                                   frm_err,
  output logic [frame_disasm_pkg::num_chans-1:0] cfc_rem
);

  logic ack_any;

  // nak shares the record and differs only in is_ack
  assign ack_any = evt.ack || evt.nak;

  // --------------------
  // ack/nak record
  // --------------------
  always_ff @(posedge clk)
  begin
    if (ack_any)
    begin
      ack.is_ack <= evt.ack;
      ack.clr    <= evt.clr;
      ack.seq    <= evt.seq;
    end
  end

  // one-cycle valid
  always_ff @(posedge clk or posedge rst)
  begin
    if (rst)
      ack_vld <= 1'b0;
    else
      ack_vld <= ack_any;
  end

  // --------------------
  // remote flow control
  // --------------------
  // all channels open until the far end says otherwise
  always_ff @(posedge clk or posedge rst)
  begin
    if (rst)
      cfc_rem <= '1;
    else if (evt.cfc || evt.dat_end)
      cfc_rem <= evt.mask;
  end

  // --------------------
  // frame pulses
  // --------------------
  // frm_vld lines up with the slot pkt_vld pulses
  always_ff @(posedge clk or posedge rst)
  begin
    if (rst)
      frm_vld <= 1'b0;
    else
      frm_vld <= evt.dat_end;
  end

  // one framing-error pulse per bad word
  always_ff @(posedge clk or posedge rst)
  begin
    if (rst)
      frm_err <= 1'b0;
    else
      frm_err <= evt.frm_err;
  end

endmodule

//--- verilog/pkt_slot.sv
`timescale 1ns/100ps

module pkt_slot
#(
  parameter int slot_idx = 0
)
(
  input  logic                      clk,
  input  logic                      rst,
  input  frame_disasm_pkg::slot_wr_t slot_wr,
  input  logic                      commit,
  output frame_disasm_pkg::pkt_t    pkt,
  output logic                      pkt_vld
);

  frame_disasm_pkg::pkt_t pkt_q;
  logic                   hdr_mine;
  logic                   sel_mine;

  // slots 0 to 3 read header word 0 and slots 4 to 7 header word 1
  assign hdr_mine = slot_wr.hdr[slot_idx / frame_disasm_pkg::hdr_per_word];
  assign sel_mine = slot_wr.sel[slot_idx];

  // --------------------
  // field capture
  // --------------------
  always_ff @(posedge clk)
  begin
    if (hdr_mine)
      pkt_q.hdr <= slot_wr.word[(slot_idx % frame_disasm_pkg::hdr_per_word) *
                                frame_disasm_pkg::hdr_bits +: frame_disasm_pkg::hdr_bits];
    // key word starts a new packet with no payload yet
    if (slot_wr.key && sel_mine)
    begin
      pkt_q.key     <= slot_wr.word;
      pkt_q.has_pld <= 1'b0;
    end
    if (slot_wr.pld && sel_mine)
    begin
      pkt_q.pld     <= slot_wr.word;
      pkt_q.has_pld <= 1'b1;
    end
  end

  assign pkt = pkt_q;

  // valid one cycle after commit
  always_ff @(posedge clk or posedge rst)
  begin
    if (rst)
      pkt_vld <= 1'b0;
    else
      pkt_vld <= commit;
  end

endmodule
